//--- hdl/hash_table_pkg.sv
package hash_table_pkg;

  localparam int KEY_WIDTH        = 16;
  localparam int VALUE_WIDTH      = 16;
  localparam int TABLE_ADDR_WIDTH = 5;
  localparam int TABLE_DEPTH      = 32;
  localparam int BUCKET_WIDTH     = 3;
  localparam int BUCKET_CNT       = 1 << BUCKET_WIDTH;

  // key split into bucket-wide slices, the last one zero padded
  localparam int HASH_SLICES = ( KEY_WIDTH + BUCKET_WIDTH - 1 ) / BUCKET_WIDTH;

  localparam logic [TABLE_ADDR_WIDTH-1:0] ADDR_ONE  = TABLE_ADDR_WIDTH'( 1 );
  localparam logic [TABLE_ADDR_WIDTH-1:0] LAST_ADDR = TABLE_ADDR_WIDTH'( TABLE_DEPTH - 1 );

  typedef enum logic [1:0] {
    OP_SEARCH = 2'd0,
    OP_INSERT = 2'd1,
    OP_DELETE = 2'd2
  } ht_opcode_t;

  typedef enum logic [1:0] {
    ST_OK         = 2'd0,
    ST_NOT_FOUND  = 2'd1,
    ST_KEY_EXISTS = 2'd2,
    ST_TABLE_FULL = 2'd3
  } ht_status_t;

  typedef struct packed {
    ht_opcode_t              opcode;
    logic [KEY_WIDTH-1:0]    key;
    logic [VALUE_WIDTH-1:0]  value;
  } ht_cmd_t;

  typedef struct packed {
    ht_opcode_t              opcode;
    ht_status_t              status;
    logic [VALUE_WIDTH-1:0]  value;
  } ht_result_t;

  typedef struct packed {
    logic [KEY_WIDTH-1:0]        key;
    logic [VALUE_WIDTH-1:0]      value;
    logic [TABLE_ADDR_WIDTH-1:0] next_ptr;
    logic                        next_ptr_val;
  } ram_entry_t;

  typedef struct packed {
    logic [KEY_WIDTH-1:0]        key;
    logic [TABLE_ADDR_WIDTH-1:0] ptr;
    logic                        ptr_val;
    logic                        en;
  } head_wr_t;

  typedef struct packed {
    logic [TABLE_ADDR_WIDTH-1:0] addr;
    ram_entry_t                  data;
    logic                        en;
  } ram_wr_t;

  // xor fold: five full slices plus the top key bit padded with zeros
  function automatic logic [BUCKET_WIDTH-1:0] bucket_hash( input logic [KEY_WIDTH-1:0] key );
    logic [HASH_SLICES*BUCKET_WIDTH-1:0] padded;
    logic [BUCKET_WIDTH-1:0]             h;
    padded                = '0;
    padded[KEY_WIDTH-1:0] = key;
    h                     = '0;
    for( int i = 0; i < HASH_SLICES; i++ )
      h = h ^ padded[i*BUCKET_WIDTH +: BUCKET_WIDTH];
    return h;
  endfunction

endpackage

//--- hdl/bucket_head_table.sv
`timescale 1ns/1ps

module bucket_head_table(
  input                                               clk_i,
  input                                               rst_i,

  input        [hash_table_pkg::KEY_WIDTH-1:0]        lookup_key_i,
  output logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] head_ptr_o,
  output logic                                        head_ptr_val_o,

  input  hash_table_pkg::head_wr_t                    head_wr_i,
  input                                               clear_i
);

logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] head_ptr   [hash_table_pkg::BUCKET_CNT-1:0];
logic [hash_table_pkg::BUCKET_CNT-1:0]       head_val;

logic [hash_table_pkg::BUCKET_WIDTH-1:0]     lookup_bucket;
logic [hash_table_pkg::BUCKET_WIDTH-1:0]     wr_bucket;

assign lookup_bucket = hash_table_pkg::bucket_hash( lookup_key_i );
assign wr_bucket     = hash_table_pkg::bucket_hash( head_wr_i.key );

// valid bits, dropped all at once on clear
always_ff @( posedge clk_i or posedge rst_i )
  if( rst_i )
    head_val <= '0;
  else
    begin
      if( clear_i )
        head_val <= '0;
      else
        if( head_wr_i.en )
          head_val[wr_bucket] <= head_wr_i.ptr_val;
    end

always_ff @( posedge clk_i )
  if( head_wr_i.en )
    head_ptr[wr_bucket] <= head_wr_i.ptr;

// lookup result shows up one cycle after the key
always_ff @( posedge clk_i or posedge rst_i )
  if( rst_i )
    head_ptr_val_o <= 1'b0;
  else
    head_ptr_val_o <= head_val[lookup_bucket];

always_ff @( posedge clk_i )
  head_ptr_o <= head_ptr[lookup_bucket];

endmodule

//--- hdl/chain_data_ram.sv
`timescale 1ns/1ps

module chain_data_ram(
  input                                               clk_i,

  input        [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_i,
  input                                               rd_en_i,
  output hash_table_pkg::ram_entry_t                  rd_data_o,

  input  hash_table_pkg::ram_wr_t                     wr_i
);

hash_table_pkg::ram_entry_t mem [hash_table_pkg::TABLE_DEPTH-1:0];

// write port
always_ff @( posedge clk_i )
  if( wr_i.en )
    mem[wr_i.addr] <= wr_i.data;

// read port, data valid the cycle after rd_en_i
always_ff @( posedge clk_i )
  if( rd_en_i )
    rd_data_o <= mem[rd_addr_i];

endmodule

//--- hdl/empty_ptr_storage.sv
`timescale 1ns/1ps

module empty_ptr_storage(
  input                                               clk_i,
  input                                               rst_i,
  input                                               clear_i,

  output logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] free_ptr_o,
  output logic                                        free_ptr_val_o,
  input                                               free_ptr_ack_i,

  input        [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] ret_ptr_i,
  input                                               ret_ptr_en_i,

  output logic                                        fill_done_o
);

logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] mem [hash_table_pkg::TABLE_DEPTH-1:0];

logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] wr_ptr;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_ptr;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] fill_cnt;
logic [hash_table_pkg::TABLE_ADDR_WIDTH:0]   count;

logic                                        push;
logic                                        pop;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] push_data;

// while filling, the fill counter is the only source of pushes
assign push      = !fill_done_o || ret_ptr_en_i;
assign push_data = fill_done_o ? ret_ptr_i : fill_cnt;
assign pop       = free_ptr_ack_i && free_ptr_val_o;

assign free_ptr_o     = mem[rd_ptr];
assign free_ptr_val_o = ( count != '0 );

always_ff @( posedge clk_i )
  if( clear_i )
    mem[0] <= '0;
  else
    if( push )
      mem[wr_ptr] <= push_data;

// clear restarts the fill, address 0 goes in on the clear cycle itself
always_ff @( posedge clk_i or posedge rst_i )
  if( rst_i )
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      fill_cnt    <= '0;
      fill_done_o <= 1'b0;
    end
  else
    if( clear_i )
      begin
        wr_ptr      <= hash_table_pkg::ADDR_ONE;
        rd_ptr      <= '0;
        count       <= { 1'b0, hash_table_pkg::ADDR_ONE };
        fill_cnt    <= hash_table_pkg::ADDR_ONE;
        fill_done_o <= 1'b0;
      end
    else
      begin
        if( !fill_done_o )
          begin
            fill_cnt <= fill_cnt + 1'b1;
            if( fill_cnt == hash_table_pkg::LAST_ADDR )
              fill_done_o <= 1'b1;
          end

        if( push )
          wr_ptr <= wr_ptr + 1'b1;

        if( pop )
          rd_ptr <= rd_ptr + 1'b1;

        case( { push, pop } )
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end

endmodule

//--- hdl/table_engine_ctrl.sv
`timescale 1ns/1ps

module table_engine_ctrl(
  input                                               clk_i,
  input                                               rst_i,

  input  hash_table_pkg::ht_cmd_t                     cmd_i,
  input                                               cmd_valid_i,
  output logic                                        cmd_ready_o,

  output hash_table_pkg::ht_result_t                  result_o,
  output logic                                        result_valid_o,
  input                                               result_ready_i,

  input                                               clear_run_i,
  output logic                                        clear_done_o,
  output logic                                        clear_o,

  output logic [hash_table_pkg::KEY_WIDTH-1:0]        head_lookup_key_o,
  input        [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] head_ptr_i,
  input                                               head_ptr_val_i,
  output hash_table_pkg::head_wr_t                    head_wr_o,

  output logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_o,
  output logic                                        rd_en_o,
  input  hash_table_pkg::ram_entry_t                  rd_data_i,
  output hash_table_pkg::ram_wr_t                     ram_wr_o,

  input        [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] free_ptr_i,
  input                                               free_ptr_val_i,
  output logic                                        free_ptr_ack_o,
  output logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] ret_ptr_o,
  output logic                                        ret_ptr_en_o,
  input                                               fill_done_i
);

typedef enum logic [3:0] {
  S_IDLE,
  S_HEAD,
  S_READ,
  S_CHECK,
  S_LINK_WR,
  S_HEAD_WR,
  S_RESULT,
  S_CLEAR,
  S_CLEAR_WAIT
} state_t;

state_t                                      state;
state_t                                      state_nxt;
state_t                                      miss_state;

hash_table_pkg::ht_cmd_t                     cmd_r;
hash_table_pkg::ht_result_t                  result_r;
hash_table_pkg::ram_entry_t                  prev_entry;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] cur_ptr;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] prev_ptr;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] alloc_ptr;
logic                                        prev_val;

logic                                        cmd_take;
logic                                        is_insert;
logic                                        key_hit;
logic                                        del_hit;
logic                                        walk_next;
logic                                        walk_miss;

assign cmd_ready_o = ( state == S_IDLE ) && fill_done_i && !clear_run_i;
assign cmd_take    = cmd_valid_i && cmd_ready_o;

assign is_insert = ( cmd_r.opcode == hash_table_pkg::OP_INSERT );
assign key_hit   = ( state == S_CHECK ) && ( rd_data_i.key == cmd_r.key );
assign del_hit   = key_hit && ( cmd_r.opcode == hash_table_pkg::OP_DELETE );
assign walk_next = ( state == S_CHECK ) && !key_hit && rd_data_i.next_ptr_val;
assign walk_miss = ( ( state == S_HEAD ) && !head_ptr_val_i ) ||
                   ( ( state == S_CHECK ) && !key_hit && !rd_data_i.next_ptr_val );

// end of chain: an insert with a free slot goes on to write
assign miss_state = ( is_insert && free_ptr_val_i ) ? S_LINK_WR : S_RESULT;

always_ff @( posedge clk_i or posedge rst_i )
  if( rst_i )
    state <= S_IDLE;
  else
    state <= state_nxt;

always_comb
  begin
    state_nxt = state;
    case( state )
      S_IDLE:
        begin
          if( clear_run_i )
            state_nxt = S_CLEAR;
          else
            if( cmd_take )
              state_nxt = S_HEAD;
        end
      S_HEAD:       state_nxt = head_ptr_val_i ? S_READ : miss_state;
      S_READ:       state_nxt = S_CHECK;
      S_CHECK:
        begin
          if( key_hit )
            state_nxt = S_RESULT;
          else
            state_nxt = rd_data_i.next_ptr_val ? S_READ : miss_state;
        end
      S_LINK_WR:    state_nxt = S_HEAD_WR;
      S_HEAD_WR:    state_nxt = S_RESULT;
      S_RESULT:     state_nxt = result_ready_i ? S_IDLE : S_RESULT;
      S_CLEAR:      state_nxt = S_CLEAR_WAIT;
      S_CLEAR_WAIT: state_nxt = fill_done_i ? S_IDLE : S_CLEAR_WAIT;
      default:      state_nxt = S_IDLE;
    endcase
  end

always_ff @( posedge clk_i )
  begin
    if( cmd_take )
      begin
        cmd_r           <= cmd_i;
        result_r.opcode <= cmd_i.opcode;
        result_r.status <= hash_table_pkg::ST_OK;
        result_r.value  <= '0;
      end

    if( state == S_HEAD )
      begin
        cur_ptr  <= head_ptr_i;
        prev_val <= 1'b0;
      end

    // step along the chain, keeping the entry we came from
    if( walk_next )
      begin
        prev_ptr   <= cur_ptr;
        prev_entry <= rd_data_i;
        prev_val   <= 1'b1;
        cur_ptr    <= rd_data_i.next_ptr;
      end

    if( state == S_LINK_WR )
      alloc_ptr <= free_ptr_i;

    if( key_hit )
      begin
        result_r.status <= is_insert ? hash_table_pkg::ST_KEY_EXISTS : hash_table_pkg::ST_OK;
        result_r.value  <= is_insert ? '0 : rd_data_i.value;
      end

    if( walk_miss && ( miss_state == S_RESULT ) )
      result_r.status <= is_insert ? hash_table_pkg::ST_TABLE_FULL : hash_table_pkg::ST_NOT_FOUND;
  end

assign head_lookup_key_o = ( state == S_IDLE ) ? cmd_i.key : cmd_r.key;

assign rd_addr_o      = cur_ptr;
assign rd_en_o        = ( state == S_READ );
assign free_ptr_ack_o = ( state == S_LINK_WR );
assign ret_ptr_o      = cur_ptr;
assign ret_ptr_en_o   = del_hit;

assign clear_o        = ( state == S_CLEAR );
assign clear_done_o   = ( state == S_CLEAR_WAIT ) && fill_done_i;

assign result_o       = result_r;
assign result_valid_o = ( state == S_RESULT );

always_comb
  begin
    // new entry links to the old head and becomes the head
    head_wr_o.key     = cmd_r.key;
    head_wr_o.ptr     = alloc_ptr;
    head_wr_o.ptr_val = 1'b1;
    head_wr_o.en      = ( state == S_HEAD_WR );

    ram_wr_o.addr              = free_ptr_i;
    ram_wr_o.data.key          = cmd_r.key;
    ram_wr_o.data.value        = cmd_r.value;
    ram_wr_o.data.next_ptr     = head_ptr_i;
    ram_wr_o.data.next_ptr_val = head_ptr_val_i;
    ram_wr_o.en                = ( state == S_LINK_WR );

    // delete unlinks in the same cycle the key matches
    if( del_hit )
      begin
        if( prev_val )
          begin
            ram_wr_o.addr              = prev_ptr;
            ram_wr_o.data              = prev_entry;
            ram_wr_o.data.next_ptr     = rd_data_i.next_ptr;
            ram_wr_o.data.next_ptr_val = rd_data_i.next_ptr_val;
            ram_wr_o.en                = 1'b1;
          end
        else
          begin
            head_wr_o.ptr     = rd_data_i.next_ptr;
            head_wr_o.ptr_val = rd_data_i.next_ptr_val;
            head_wr_o.en      = 1'b1;
          end
      end
  end

endmodule

//--- hdl/hash_table_top.sv
`timescale 1ns/1ps

module hash_table_top(
  input                               clk_i,
  input                               rst_i,

  input  hash_table_pkg::ht_cmd_t     cmd_i,
  input                               cmd_valid_i,
  output logic                        cmd_ready_o,

  output hash_table_pkg::ht_result_t  result_o,
  output logic                        result_valid_o,
  input                               result_ready_i,

  input                               clear_run_i,
  output logic                        clear_done_o
);

logic [hash_table_pkg::KEY_WIDTH-1:0]        head_lookup_key;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] head_ptr;
logic                                        head_ptr_val;
hash_table_pkg::head_wr_t                    head_wr;

logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr;
logic                                        rd_en;
hash_table_pkg::ram_entry_t                  rd_data;
hash_table_pkg::ram_wr_t                     ram_wr;

logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] free_ptr;
logic                                        free_ptr_val;
logic                                        free_ptr_ack;
logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] ret_ptr;
logic                                        ret_ptr_en;
logic                                        fill_done;
logic                                        clear;

table_engine_ctrl table_engine_ctrl_inst (
  .clk_i             ( clk_i           ),
  .rst_i             ( rst_i           ),
  .cmd_i             ( cmd_i           ),
  .cmd_valid_i       ( cmd_valid_i     ),
  .cmd_ready_o       ( cmd_ready_o     ),
  .result_o          ( result_o        ),
  .result_valid_o    ( result_valid_o  ),
  .result_ready_i    ( result_ready_i  ),
  .clear_run_i       ( clear_run_i     ),
  .clear_done_o      ( clear_done_o    ),
  .clear_o           ( clear           ),
  .head_lookup_key_o ( head_lookup_key ),
  .head_ptr_i        ( head_ptr        ),
  .head_ptr_val_i    ( head_ptr_val    ),
  .head_wr_o         ( head_wr         ),
  .rd_addr_o         ( rd_addr         ),
  .rd_en_o           ( rd_en           ),
  .rd_data_i         ( rd_data         ),
  .ram_wr_o          ( ram_wr          ),
  .free_ptr_i        ( free_ptr        ),
  .free_ptr_val_i    ( free_ptr_val    ),
  .free_ptr_ack_o    ( free_ptr_ack    ),
  .ret_ptr_o         ( ret_ptr         ),
  .ret_ptr_en_o      ( ret_ptr_en      ),
  .fill_done_i       ( fill_done       )
);

bucket_head_table bucket_head_table_inst (
  .clk_i          ( clk_i           ),
  .rst_i          ( rst_i           ),
  .lookup_key_i   ( head_lookup_key ),
  .head_ptr_o     ( head_ptr        ),
  .head_ptr_val_o ( head_ptr_val    ),
  .head_wr_i      ( head_wr         ),
  .clear_i        ( clear           )
);

chain_data_ram chain_data_ram_inst (
  .clk_i     ( clk_i   ),
  .rd_addr_i ( rd_addr ),
  .rd_en_i   ( rd_en   ),
  .rd_data_o ( rd_data ),
  .wr_i      ( ram_wr  )
);

empty_ptr_storage empty_ptr_storage_inst (
  .clk_i          ( clk_i        ),
  .rst_i          ( rst_i        ),
  .clear_i        ( clear        ),
  .free_ptr_o     ( free_ptr     ),
  .free_ptr_val_o ( free_ptr_val ),
  .free_ptr_ack_i ( free_ptr_ack ),
  .ret_ptr_i      ( ret_ptr      ),
  .ret_ptr_en_i   ( ret_ptr_en   ),
  .fill_done_o    ( fill_done    )
);

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int CLK_PERIOD   = 10,
  parameter int RESET_CYCLES = 8
)(
  output logic clk_o,
  output logic rst_o
);

initial
  begin
    clk_o = 1'b0;
    forever #( CLK_PERIOD / 2 ) clk_o = ~clk_o;
  end

// reset released on a rising edge after RESET_CYCLES cycles
initial
  begin
    rst_o = 1'b1;
    repeat( RESET_CYCLES ) @( posedge clk_o );
    rst_o <= 1'b0;
  end

endmodule

//--- tb/hash_table_tb.sv
`timescale 1ns/1ps

module hash_table_tb;

localparam int STEP_CYCLES = hash_table_pkg::TABLE_DEPTH * 2 + 20;
localparam int FILL_CYCLES = hash_table_pkg::TABLE_DEPTH + 8 + 4;

typedef struct packed {
  logic                       is_clear;
  hash_table_pkg::ht_cmd_t    cmd;
  hash_table_pkg::ht_result_t expected;
} step_t;

logic                              clk;
logic                              rst;
hash_table_pkg::ht_cmd_t           cmd;
logic                              cmd_valid;
logic                              cmd_ready;
hash_table_pkg::ht_result_t        result;
logic                              result_valid;
logic                              result_ready;
logic                              clear_run;
logic                              clear_done;

step_t                             steps[$];
string                             step_names[$];
logic [hash_table_pkg::VALUE_WIDTH-1:0] model_mem [logic [hash_table_pkg::KEY_WIDTH-1:0]];
int                                model_count;
logic [31:0]                       lfsr_state = 32'h4353_6939;
int                                error_count;
int                                check_count;
int                                take_count;
int                                result_count;
logic                              table_ready;

tb_clock_gen tb_clock_gen_inst (
  .clk_o ( clk ),
  .rst_o ( rst )
);

hash_table_top hash_table_top_inst (
  .clk_i          ( clk          ),
  .rst_i          ( rst          ),
  .cmd_i          ( cmd          ),
  .cmd_valid_i    ( cmd_valid    ),
  .cmd_ready_o    ( cmd_ready    ),
  .result_o       ( result       ),
  .result_valid_o ( result_valid ),
  .result_ready_i ( result_ready ),
  .clear_run_i    ( clear_run    ),
  .clear_done_o   ( clear_done   )
);

function automatic logic [31:0] lfsr_next( input logic [31:0] s );
  if( s[0] )
    return ( s >> 1 ) ^ 32'h8020_0003;
  else
    return s >> 1;
endfunction

// bit i of the key lands in bucket bit i mod 3
function automatic logic [2:0] fold_key( input logic [15:0] key );
  logic [2:0] h;
  h = '0;
  for( int i = 0; i < 16; i++ )
    h[i % 3] = h[i % 3] ^ key[i];
  return h;
endfunction

task automatic find_mates( input logic [15:0] start, output logic [15:0] k0,
                           output logic [15:0] k1, output logic [15:0] k2 );
  logic [15:0] cand;
  k0   = start;
  cand = start + 16'd1;
  while( fold_key( cand ) != fold_key( start ) )
    cand = cand + 16'd1;
  k1   = cand;
  cand = cand + 16'd1;
  while( fold_key( cand ) != fold_key( start ) )
    cand = cand + 16'd1;
  k2   = cand;
endtask

// expected result comes from the key/value model
task automatic add_op( input string name, input hash_table_pkg::ht_opcode_t op,
                       input logic [15:0] key, input logic [15:0] value );
  step_t s;
  s.is_clear        = 1'b0;
  s.cmd.opcode      = op;
  s.cmd.key         = key;
  s.cmd.value       = value;
  s.expected.opcode = op;
  s.expected.status = hash_table_pkg::ST_NOT_FOUND;
  s.expected.value  = '0;
  case( op )
    hash_table_pkg::OP_SEARCH:
      if( model_mem.exists( key ) )
        begin
          s.expected.status = hash_table_pkg::ST_OK;
          s.expected.value  = model_mem[key];
        end
    hash_table_pkg::OP_INSERT:
      if( model_mem.exists( key ) )
        s.expected.status = hash_table_pkg::ST_KEY_EXISTS;
      else if( model_count == hash_table_pkg::TABLE_DEPTH )
        s.expected.status = hash_table_pkg::ST_TABLE_FULL;
      else
        begin
          model_mem[key]    = value;
          model_count       = model_count + 1;
          s.expected.status = hash_table_pkg::ST_OK;
        end
    default:
      if( model_mem.exists( key ) )
        begin
          s.expected.status = hash_table_pkg::ST_OK;
          s.expected.value  = model_mem[key];
          model_mem.delete( key );
          model_count       = model_count - 1;
        end
  endcase
  steps.push_back( s );
  step_names.push_back( name );
endtask

task automatic add_clear( input string name );
  step_t s;
  s          = '0;
  s.is_clear = 1'b1;
  model_mem.delete();
  model_count = 0;
  steps.push_back( s );
  step_names.push_back( name );
endtask

task automatic build_table();
  logic [15:0] k0;
  logic [15:0] k1;
  logic [15:0] k2;
  int          i;
  add_op( "insert basic", hash_table_pkg::OP_INSERT, 16'h1234, 16'hbeef );
  add_op( "search basic", hash_table_pkg::OP_SEARCH, 16'h1234, '0 );
  add_op( "search missing", hash_table_pkg::OP_SEARCH, 16'h4321, '0 );
  add_op( "delete basic", hash_table_pkg::OP_DELETE, 16'h1234, '0 );
  // three keys in one bucket chain up as k2 then k1 then k0
  find_mates( 16'h0c35, k0, k1, k2 );
  add_op( "chain insert 0", hash_table_pkg::OP_INSERT, k0, 16'h1100 );
  add_op( "chain insert 1", hash_table_pkg::OP_INSERT, k1, 16'h1101 );
  add_op( "chain insert 2", hash_table_pkg::OP_INSERT, k2, 16'h1102 );
  add_op( "chain search 0", hash_table_pkg::OP_SEARCH, k0, '0 );
  add_op( "chain search 1", hash_table_pkg::OP_SEARCH, k1, '0 );
  add_op( "chain search 2", hash_table_pkg::OP_SEARCH, k2, '0 );
  add_op( "chain delete middle", hash_table_pkg::OP_DELETE, k1, '0 );
  add_op( "after middle 0", hash_table_pkg::OP_SEARCH, k0, '0 );
  add_op( "after middle 1", hash_table_pkg::OP_SEARCH, k1, '0 );
  add_op( "after middle 2", hash_table_pkg::OP_SEARCH, k2, '0 );
  add_op( "chain delete head", hash_table_pkg::OP_DELETE, k2, '0 );
  add_op( "after head 0", hash_table_pkg::OP_SEARCH, k0, '0 );
  add_op( "chain reinsert 1", hash_table_pkg::OP_INSERT, k1, 16'h1101 );
  add_op( "chain reinsert 2", hash_table_pkg::OP_INSERT, k2, 16'h1102 );
  add_op( "chain delete tail", hash_table_pkg::OP_DELETE, k0, '0 );
  add_op( "after tail 0", hash_table_pkg::OP_SEARCH, k0, '0 );
  add_op( "after tail 1", hash_table_pkg::OP_SEARCH, k1, '0 );
  add_op( "after tail 2", hash_table_pkg::OP_SEARCH, k2, '0 );
  add_op( "insert existing", hash_table_pkg::OP_INSERT, k1, 16'h5555 );
  add_op( "old value kept", hash_table_pkg::OP_SEARCH, k1, '0 );
  add_op( "delete missing", hash_table_pkg::OP_DELETE, 16'h4321, '0 );
  i = 0;
  while( model_count < hash_table_pkg::TABLE_DEPTH )
    begin
      add_op( $sformatf( "fill insert %0d", i ), hash_table_pkg::OP_INSERT,
              16'h8000 + 16'( i ), 16'( i ) ^ 16'h00ff );
      i++;
    end
  add_op( "insert when full", hash_table_pkg::OP_INSERT, 16'h9000, 16'h0900 );
  add_op( "search when full", hash_table_pkg::OP_SEARCH, 16'h8005, '0 );
  add_op( "delete when full", hash_table_pkg::OP_DELETE, 16'h8000, '0 );
  add_op( "insert after delete", hash_table_pkg::OP_INSERT, 16'h9000, 16'h0900 );
  add_op( "search after delete", hash_table_pkg::OP_SEARCH, 16'h9000, '0 );
  add_clear( "clear" );
  add_op( "cleared 1", hash_table_pkg::OP_SEARCH, k1, '0 );
  add_op( "cleared 2", hash_table_pkg::OP_SEARCH, k2, '0 );
  add_op( "cleared fill", hash_table_pkg::OP_SEARCH, 16'h8001, '0 );
  add_op( "cleared late", hash_table_pkg::OP_SEARCH, 16'h9000, '0 );
  for( int j = 0; j < hash_table_pkg::TABLE_DEPTH; j++ )
    add_op( $sformatf( "refill insert %0d", j ), hash_table_pkg::OP_INSERT,
            16'ha000 + 16'( j * 3 ), 16'( j ) + 16'h3000 );
  add_op( "refill full", hash_table_pkg::OP_INSERT, 16'hb000, 16'h0001 );
  add_op( "refill search first", hash_table_pkg::OP_SEARCH, 16'ha000, '0 );
  add_op( "refill search last", hash_table_pkg::OP_SEARCH, 16'ha05d, '0 );
endtask

task automatic check_status( input string name, input hash_table_pkg::ht_status_t exp,
                             input hash_table_pkg::ht_status_t act );
  check_count++;
  if( act !== exp )
    begin
      error_count++;
      $display( "ERROR %s expected status %s actual status %s", name, exp.name(), act.name() );
    end
endtask

task automatic check_result( input string name, input hash_table_pkg::ht_result_t exp,
                             input hash_table_pkg::ht_result_t act );
  check_count++;
  if( act !== exp )
    begin
      error_count++;
      $display( "ERROR %s expected %s/%s/%h actual %s/%s/%h", name, exp.opcode.name(),
                exp.status.name(), exp.value, act.opcode.name(), act.status.name(), act.value );
    end
endtask

task automatic check_latency( input string name, input int exp, input int act );
  check_count++;
  if( act != exp )
    begin
      error_count++;
      $display( "ERROR %s expected %0d cycles actual %0d cycles", name, exp, act );
    end
endtask

task automatic send_command( input hash_table_pkg::ht_cmd_t c, output logic taken );
  int cycles;
  @( posedge clk );
  cmd          <= c;
  cmd_valid    <= 1'b1;
  result_ready <= 1'b0;
  taken        = 1'b0;
  cycles       = 0;
  while( !taken && cycles < STEP_CYCLES )
    begin
      @( negedge clk );
      cycles++;
      taken = cmd_ready;
    end
  // the command stays offered while the DUT works on it
  @( posedge clk );
endtask

// ready follows the LFSR and a stalled result has to stay put
task automatic collect_result( output hash_table_pkg::ht_result_t res, output logic got );
  hash_table_pkg::ht_result_t held;
  logic                       held_val;
  int                         cycles;
  got      = 1'b0;
  held_val = 1'b0;
  held     = '0;
  res      = '0;
  cycles   = 0;
  while( !got && cycles < STEP_CYCLES )
    begin
      @( posedge clk );
      result_ready <= lfsr_state[0];
      lfsr_state   = lfsr_next( lfsr_state );
      @( negedge clk );
      cycles++;
      if( result_valid )
        begin
          if( held_val && result !== held )
            begin
              error_count++;
              $display( "result changed while the output was stalled" );
            end
          held     = result;
          held_val = 1'b1;
          if( result_ready )
            begin
              res = result;
              got = 1'b1;
            end
        end
    end
endtask

task automatic run_clear( input string name );
  int   cycles;
  logic seen;
  @( posedge clk );
  clear_run    <= 1'b1;
  cmd_valid    <= 1'b0;
  result_ready <= 1'b0;
  @( posedge clk );
  clear_run <= 1'b0;
  cycles = 0;
  seen   = 1'b0;
  while( !seen && cycles < STEP_CYCLES )
    begin
      @( negedge clk );
      cycles++;
      seen = clear_done;
    end
  if( !seen )
    begin
      error_count++;
      $display( "step %s: clear_done_o never came", name );
    end
  else
    begin
      check_latency( name, hash_table_pkg::TABLE_DEPTH + 1, cycles );
      @( negedge clk );
      if( clear_done )
        begin
          error_count++;
          $display( "step %s: clear_done_o stayed high for more than one cycle", name );
        end
    end
endtask

// only one command may be in flight at any time
always @( negedge clk )
  if( !rst )
    begin
      if( cmd_valid && cmd_ready )
        take_count++;
      if( result_valid && result_ready )
        result_count++;
      if( result_valid && cmd_ready )
        begin
          error_count++;
          $display( "command input was ready while a result was pending" );
        end
      if( take_count - result_count > 1 )
        begin
          error_count++;
          $display( "a second command was taken before the previous result" );
        end
    end

initial
  begin
    int                         limit;
    wait( table_ready );
    limit = steps.size() * STEP_CYCLES + FILL_CYCLES;
    repeat( limit ) @( posedge clk );
    $display( "watchdog expired after %0d cycles, the run did not finish", limit );
    $display( "Checks failed" );
    $finish;
  end

initial
  begin
    hash_table_pkg::ht_result_t res;
    logic                       taken;
    logic                       got;
    logic                       aborted;
    int                         idx;
    cmd          = '0;
    cmd_valid    = 1'b0;
    result_ready = 1'b0;
    clear_run    = 1'b0;
    error_count  = 0;
    check_count  = 0;
    take_count   = 0;
    result_count = 0;
    model_count  = 0;
    table_ready  = 1'b0;
    build_table();
    table_ready = 1'b1;

    @( negedge clk );
    if( cmd_ready || result_valid || clear_done )
      begin
        error_count++;
        $display( "DUT outputs were not low during reset" );
      end
    while( rst )
      @( negedge clk );

    idx     = 0;
    aborted = 1'b0;
    while( idx < steps.size() && !aborted )
      begin
        if( steps[idx].is_clear )
          run_clear( step_names[idx] );
        else
          begin
            send_command( steps[idx].cmd, taken );
            if( !taken )
              begin
                error_count++;
                aborted = 1'b1;
                $display( "step %s: the command was never accepted", step_names[idx] );
              end
            else
              begin
                collect_result( res, got );
                if( !got )
                  begin
                    error_count++;
                    aborted = 1'b1;
                    $display( "step %s: no result arrived", step_names[idx] );
                  end
                else
                  begin
                    check_status( step_names[idx], steps[idx].expected.status, res.status );
                    if( res.status == steps[idx].expected.status )
                      check_result( step_names[idx], steps[idx].expected, res );
                  end
              end
          end
        idx++;
      end

    $display( "%0d errors in %0d checks over %0d steps", error_count, check_count, idx );
    if( error_count == 0 )
      $display( "All checks passed" );
    else
      $display( "Checks failed" );
    $finish;
  end

endmodule

//--- flist.f
hdl/hash_table_pkg.sv
hdl/bucket_head_table.sv
hdl/chain_data_ram.sv
hdl/empty_ptr_storage.sv
hdl/table_engine_ctrl.sv
hdl/hash_table_top.sv
tb/tb_clock_gen.sv
tb/hash_table_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing
TOP   = hash_table_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log
PASS  = All checks passed

SOURCES = $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

# the log decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
